// File: verilog/ppu_pkg.sv
package ppu_pkg;

    // widths that carry a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] ppu_addr_t;
    typedef logic [10:0] vram_addr_t;
    typedef logic [4:0]  pal_addr_t;
    typedef logic [7:0]  oam_addr_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [10:0] wram_addr_t;

    // cpu-visible register select
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_t;

    // nametable mirroring
    typedef enum logic {
        HOR_MIRROR = 1'b0,
        VER_MIRROR = 1'b1
    } mirror_t;

    // one memory request, addr narrowed by each memory
    typedef struct packed {
        vram_addr_t addr;
        logic       we;
        logic       re;
        byte_t      wr_data;
    } mem_port_t;

    // status flag events from the video side
    typedef struct packed {
        logic sp_over_set;
        logic sp_over_clr;
        logic sp_zero_set;
        logic sp_zero_clr;
        logic vblank_set;
        logic vblank_clr;
    } status_evt_t;

    // nametable window in the 14-bit video space
    localparam logic [13:0] NT_LO = 14'h2000;
    localparam logic [13:0] NT_HI = 14'h3EFF;

    // palette window runs to the top of the space
    localparam logic [13:0] PAL_LO = 14'h3F00;

    // video address step when ctrl bit 2 is set
    localparam ppu_addr_t INC_ACROSS = 16'd32;

    // bytes per sprite dma
    localparam int DMA_LEN = 256;

endpackage

// File: verilog/ppu_reg_file.sv
`timescale 1ns/10ps

module ppu_reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_clk_en,
    input  logic                 ppu_clk_en,
    input  ppu_pkg::reg_t        reg_sel,
    input  logic                 reg_en,
    input  logic                 reg_rw,
    input  ppu_pkg::byte_t       reg_data_in,
    output ppu_pkg::byte_t       reg_data_out,
    input  ppu_pkg::mirror_t     mirroring,
    input  ppu_pkg::status_evt_t status_evt,
    input  ppu_pkg::byte_t       oam_rd,
    input  ppu_pkg::byte_t       vram_rd,
    input  ppu_pkg::byte_t       pal_rd,
    output ppu_pkg::mem_port_t   oam_req,
    output ppu_pkg::mem_port_t   vram_req,
    output ppu_pkg::mem_port_t   pal_req,
    output logic                 dma_start,
    output ppu_pkg::byte_t       dma_page,
    output ppu_pkg::byte_t       oam_base,
    output ppu_pkg::byte_t       ppuctrl,
    output ppu_pkg::byte_t       ppumask,
    output ppu_pkg::byte_t       scroll_x,
    output ppu_pkg::byte_t       scroll_y
);

    // shared first/second write toggle for scroll and address
    typedef enum logic {
        FIRST_WR,
        SECOND_WR
    } wr_latch_t;

    wr_latch_t           wr_latch;
    ppu_pkg::ppu_addr_t  ppu_addr;
    ppu_pkg::oam_addr_t  oam_addr;
    ppu_pkg::byte_t      read_buf;
    logic [4:0]          last_wr;
    logic                sp_over;
    logic                sp_zero;
    logic                vblank;
    logic                clr_q0;
    logic                clr_q1;

    logic                acc_wr;
    logic                acc_rd;
    logic                in_nt;
    logic                in_pal;
    ppu_pkg::ppu_addr_t  addr_step;
    ppu_pkg::vram_addr_t vram_addr;
    ppu_pkg::pal_addr_t  pal_addr;
    ppu_pkg::byte_t      status;

    // accesses only count on a cpu tick
    assign acc_wr = reg_en && reg_rw && cpu_clk_en;
    assign acc_rd = reg_en && !reg_rw && cpu_clk_en;

    assign in_nt  = (ppu_addr[13:0] >= ppu_pkg::NT_LO) && (ppu_addr[13:0] <= ppu_pkg::NT_HI);
    assign in_pal = (ppu_addr[13:0] >= ppu_pkg::PAL_LO);

    assign addr_step = ppuctrl[2] ? ppu_pkg::INC_ACROSS : 16'd1;
    assign status    = {vblank, sp_zero, sp_over, last_wr};
    assign oam_base  = oam_addr;
    assign dma_start = acc_wr && (reg_sel == ppu_pkg::OAMDMA);

    // horizontal mirroring takes nametable select from addr bit 11
    always_comb begin
        if (mirroring == ppu_pkg::VER_MIRROR) begin
            vram_addr = ppu_addr[10:0];
        end else begin
            vram_addr = {ppu_addr[11], ppu_addr[9:0]};
        end
    end

    // sprite backdrop entries alias the background ones
    always_comb begin
        if (ppu_addr[4] && (ppu_addr[1:0] == 2'b00)) begin
            pal_addr = {1'b0, ppu_addr[3:0]};
        end else begin
            pal_addr = ppu_addr[4:0];
        end
    end

    // memory requests decoded from the current access
    always_comb begin
        oam_req          = '0;
        vram_req         = '0;
        pal_req          = '0;
        oam_req.addr     = {3'b000, oam_addr};
        vram_req.addr    = vram_addr;
        pal_req.addr     = {6'b000000, pal_addr};
        oam_req.wr_data  = reg_data_in;
        vram_req.wr_data = reg_data_in;
        pal_req.wr_data  = reg_data_in;
        if (reg_sel == ppu_pkg::OAMDATA) begin
            oam_req.we = acc_wr;
            oam_req.re = acc_rd;
        end
        if (reg_sel == ppu_pkg::PPUDATA) begin
            vram_req.we = acc_wr && in_nt;
            vram_req.re = acc_rd && in_nt;
            pal_req.we  = acc_wr && in_pal;
            pal_req.re  = acc_rd && in_pal;
        end
    end

    // write-side registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl  <= '0;
            ppumask  <= '0;
            scroll_x <= '0;
            scroll_y <= '0;
            ppu_addr <= '0;
            oam_addr <= '0;
            dma_page <= '0;
            last_wr  <= '0;
            wr_latch <= FIRST_WR;
        end else if (acc_wr) begin
            last_wr <= reg_data_in[4:0];
            case (reg_sel)
                ppu_pkg::PPUCTRL: ppuctrl <= reg_data_in;
                ppu_pkg::PPUMASK: ppumask <= reg_data_in;
                ppu_pkg::OAMADDR: oam_addr <= reg_data_in;
                ppu_pkg::OAMDATA: oam_addr <= oam_addr + 8'd1;
                ppu_pkg::PPUSCROLL: begin
                    if (wr_latch == FIRST_WR) begin
                        scroll_x <= reg_data_in;
                        wr_latch <= SECOND_WR;
                    end else begin
                        scroll_y <= reg_data_in;
                        wr_latch <= FIRST_WR;
                    end
                end
                ppu_pkg::PPUADDR: begin
                    // high byte first
                    if (wr_latch == FIRST_WR) begin
                        ppu_addr[15:8] <= reg_data_in;
                        wr_latch       <= SECOND_WR;
                    end else begin
                        ppu_addr[7:0] <= reg_data_in;
                        wr_latch      <= FIRST_WR;
                    end
                end
                ppu_pkg::PPUDATA: ppu_addr <= ppu_addr + addr_step;
                ppu_pkg::OAMDMA:  dma_page <= reg_data_in;
                default: ;
            endcase
        end else if (acc_rd && (reg_sel == ppu_pkg::PPUDATA)) begin
            ppu_addr <= ppu_addr + addr_step;
        end
    end

    // read data and nametable read buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_data_out <= '0;
            read_buf     <= '0;
        end else if (acc_rd) begin
            case (reg_sel)
                ppu_pkg::PPUSTATUS: reg_data_out <= status;
                ppu_pkg::OAMDATA:   reg_data_out <= oam_rd;
                ppu_pkg::PPUDATA: begin
                    if (in_pal) begin
                        reg_data_out <= pal_rd;
                    end else if (in_nt) begin
                        // nametable data lags one read
                        reg_data_out <= read_buf;
                        read_buf     <= vram_rd;
                    end
                end
                default: ;
            endcase
        end
    end

    // status flags, clear wins over set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp_over <= 1'b0;
            sp_zero <= 1'b0;
            vblank  <= 1'b0;
            clr_q0  <= 1'b0;
            clr_q1  <= 1'b0;
        end else begin
            // status read clears vblank two ppu ticks on
            if (acc_rd && (reg_sel == ppu_pkg::PPUSTATUS)) begin
                clr_q0 <= 1'b1;
            end else if (ppu_clk_en) begin
                clr_q0 <= 1'b0;
            end
            if (ppu_clk_en) begin
                clr_q1 <= clr_q0;
                if (status_evt.sp_over_clr) begin
                    sp_over <= 1'b0;
                end else if (status_evt.sp_over_set) begin
                    sp_over <= 1'b1;
                end
                if (status_evt.sp_zero_clr) begin
                    sp_zero <= 1'b0;
                end else if (status_evt.sp_zero_set) begin
                    sp_zero <= 1'b1;
                end
                if (status_evt.vblank_clr || clr_q1) begin
                    vblank <= 1'b0;
                end else if (status_evt.vblank_set) begin
                    vblank <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/oam_dma.sv
`timescale 1ns/10ps

module oam_dma (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_clk_en,
    input  logic               cpu_cyc_par,
    input  logic               dma_start,
    input  ppu_pkg::byte_t     dma_page,
    input  ppu_pkg::byte_t     oam_base,
    input  ppu_pkg::byte_t     wram_rd,
    output ppu_pkg::cpu_addr_t cpu_addr,
    output logic               cpu_re,
    output logic               cpu_sus,
    output ppu_pkg::mem_port_t dma_oam_wr
);

    typedef enum logic [2:0] {
        IDLE,
        ALIGN1,
        ALIGN2,
        READ,
        WRITE
    } dma_state_t;

    dma_state_t         state;
    dma_state_t         state_nxt;
    ppu_pkg::byte_t     cnt;
    ppu_pkg::oam_addr_t wr_addr;
    logic               last;

    assign last     = (cnt == 8'(ppu_pkg::DMA_LEN - 1));
    assign cpu_addr = {dma_page, cnt};
    assign cpu_re   = (state == READ);
    // wraps inside the 256-byte OAM
    assign wr_addr  = oam_base + cnt;

    // cpu released already on the final write tick
    assign cpu_sus = (state != IDLE) && !((state == WRITE) && last);

    always_comb begin
        dma_oam_wr         = '0;
        dma_oam_wr.addr    = {3'b000, wr_addr};
        dma_oam_wr.wr_data = wram_rd;
        dma_oam_wr.we      = (state == WRITE) && cpu_clk_en;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (dma_start) state_nxt = ALIGN1;
            // odd cycle needs one extra wait
            ALIGN1:  state_nxt = cpu_cyc_par ? ALIGN2 : READ;
            ALIGN2:  state_nxt = READ;
            READ:    state_nxt = WRITE;
            WRITE:   state_nxt = last ? IDLE : READ;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (cpu_clk_en) begin
            state <= state_nxt;
            if (state == ALIGN1) begin
                cnt <= '0;
            end else if ((state == WRITE) && !last) begin
                cnt <= cnt + 8'd1;
            end
        end
    end

endmodule

// File: verilog/ppu_mem.sv
`timescale 1ns/10ps

module ppu_mem (
    input  logic               clk,
    input  ppu_pkg::mem_port_t oam_req,
    input  ppu_pkg::mem_port_t dma_oam_wr,
    input  ppu_pkg::mem_port_t vram_req,
    input  ppu_pkg::mem_port_t pal_req,
    output ppu_pkg::byte_t     oam_rd,
    output ppu_pkg::byte_t     vram_rd,
    output ppu_pkg::byte_t     pal_rd
);

    // sprite attribute memory
    ppu_pkg::byte_t oam_mem [0:255];

    // two physical nametables
    ppu_pkg::byte_t vram_mem [0:2047];

    ppu_pkg::byte_t pal_mem [0:31];

    ppu_pkg::mem_port_t oam_sel;

    // dma write takes the oam port for its cycle
    assign oam_sel = dma_oam_wr.we ? dma_oam_wr : oam_req;

    always_ff @(posedge clk) begin
        if (oam_sel.we) begin
            oam_mem[oam_sel.addr[7:0]] <= oam_sel.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (vram_req.we) begin
            vram_mem[vram_req.addr] <= vram_req.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (pal_req.we) begin
            pal_mem[pal_req.addr[4:0]] <= pal_req.wr_data;
        end
    end

    // async reads, zero when not requested
    assign oam_rd  = oam_sel.re ? oam_mem[oam_sel.addr[7:0]] : 8'h00;
    assign vram_rd = vram_req.re ? vram_mem[vram_req.addr] : 8'h00;
    assign pal_rd  = pal_req.re ? pal_mem[pal_req.addr[4:0]] : 8'h00;

endmodule

// File: verilog/cpu_wram.sv
`timescale 1ns/10ps

module cpu_wram (
    input  logic                clk,
    input  logic                cpu_sus,
    input  logic                wram_en,
    input  logic                wram_we,
    input  ppu_pkg::wram_addr_t wram_addr,
    input  ppu_pkg::byte_t      wram_wdata,
    output ppu_pkg::byte_t      wram_rdata,
    input  ppu_pkg::cpu_addr_t  dma_addr,
    input  logic                dma_re,
    output ppu_pkg::byte_t      dma_rd
);

    // 2 KB, mirrored through the cpu space by the low address bits
    ppu_pkg::byte_t mem [0:2047];

    ppu_pkg::wram_addr_t dma_idx;

    assign dma_idx = dma_addr[10:0];

    // cpu_sus hands the single port to the dma
    always_ff @(posedge clk) begin
        if (cpu_sus) begin
            if (dma_re) begin
                dma_rd <= mem[dma_idx];
            end
        end else if (wram_en) begin
            if (wram_we) begin
                mem[wram_addr] <= wram_wdata;
            end else begin
                wram_rdata <= mem[wram_addr];
            end
        end
    end

endmodule

// File: verilog/ppu_sys_top.sv
`timescale 1ns/10ps

module ppu_sys_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_clk_en,
    input  logic                 ppu_clk_en,
    input  logic                 cpu_cyc_par,
    input  ppu_pkg::reg_t        reg_sel,
    input  logic                 reg_en,
    input  logic                 reg_rw,
    input  ppu_pkg::byte_t       reg_data_in,
    output ppu_pkg::byte_t       reg_data_out,
    input  ppu_pkg::mirror_t     mirroring,
    input  ppu_pkg::status_evt_t status_evt,
    output logic                 cpu_sus,
    output ppu_pkg::byte_t       ppuctrl,
    output ppu_pkg::byte_t       ppumask,
    output ppu_pkg::byte_t       scroll_x,
    output ppu_pkg::byte_t       scroll_y,
    input  logic                 wram_en,
    input  logic                 wram_we,
    input  ppu_pkg::wram_addr_t  wram_addr,
    input  ppu_pkg::byte_t       wram_wdata,
    output ppu_pkg::byte_t       wram_rdata
);

    ppu_pkg::mem_port_t oam_req;
    ppu_pkg::mem_port_t vram_req;
    ppu_pkg::mem_port_t pal_req;
    ppu_pkg::mem_port_t dma_oam_wr;
    ppu_pkg::byte_t     oam_rd;
    ppu_pkg::byte_t     vram_rd;
    ppu_pkg::byte_t     pal_rd;
    ppu_pkg::byte_t     wram_rd;
    ppu_pkg::byte_t     dma_page;
    ppu_pkg::byte_t     oam_base;
    ppu_pkg::cpu_addr_t cpu_addr;
    logic               dma_start;
    logic               cpu_re;

    ppu_reg_file reg_file0 (
        .clk(clk), .rst_n(rst_n), .cpu_clk_en(cpu_clk_en), .ppu_clk_en(ppu_clk_en),
        .reg_sel(reg_sel), .reg_en(reg_en), .reg_rw(reg_rw),
        .reg_data_in(reg_data_in), .reg_data_out(reg_data_out),
        .mirroring(mirroring), .status_evt(status_evt),
        .oam_rd(oam_rd), .vram_rd(vram_rd), .pal_rd(pal_rd),
        .oam_req(oam_req), .vram_req(vram_req), .pal_req(pal_req),
        .dma_start(dma_start), .dma_page(dma_page), .oam_base(oam_base),
        .ppuctrl(ppuctrl), .ppumask(ppumask), .scroll_x(scroll_x), .scroll_y(scroll_y)
    );

    oam_dma dma0 (
        .clk(clk), .rst_n(rst_n), .cpu_clk_en(cpu_clk_en), .cpu_cyc_par(cpu_cyc_par),
        .dma_start(dma_start), .dma_page(dma_page), .oam_base(oam_base),
        .wram_rd(wram_rd), .cpu_addr(cpu_addr), .cpu_re(cpu_re),
        .cpu_sus(cpu_sus), .dma_oam_wr(dma_oam_wr)
    );

    ppu_mem mem0 (
        .clk(clk), .oam_req(oam_req), .dma_oam_wr(dma_oam_wr),
        .vram_req(vram_req), .pal_req(pal_req),
        .oam_rd(oam_rd), .vram_rd(vram_rd), .pal_rd(pal_rd)
    );

    cpu_wram wram0 (
        .clk(clk), .cpu_sus(cpu_sus), .wram_en(wram_en), .wram_we(wram_we),
        .wram_addr(wram_addr), .wram_wdata(wram_wdata), .wram_rdata(wram_rdata),
        .dma_addr(cpu_addr), .dma_re(cpu_re), .dma_rd(wram_rd)
    );

endmodule

// File: bench/tb_ppu_sys.sv
`timescale 1ns/10ps

module tb_ppu_sys;

    localparam int TICK_LIMIT = 50;
    localparam int DMA_LIMIT  = 2000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cpu_clk_en = 1'b0;
    logic                 ppu_clk_en;
    logic                 cpu_cyc_par;
    ppu_pkg::reg_t        reg_sel;
    logic                 reg_en;
    logic                 reg_rw;
    ppu_pkg::byte_t       reg_data_in;
    ppu_pkg::byte_t       reg_data_out;
    ppu_pkg::mirror_t     mirroring;
    ppu_pkg::status_evt_t status_evt;
    logic                 cpu_sus;
    ppu_pkg::byte_t       ppuctrl;
    ppu_pkg::byte_t       ppumask;
    ppu_pkg::byte_t       scroll_x;
    ppu_pkg::byte_t       scroll_y;
    logic                 wram_en;
    logic                 wram_we;
    ppu_pkg::wram_addr_t  wram_addr;
    ppu_pkg::byte_t       wram_wdata;
    ppu_pkg::byte_t       wram_rdata;

    int unsigned    cyc = 0;
    int unsigned    lcg_state;
    int             errors;
    int             checks;
    logic [4:0]     last_wr;
    ppu_pkg::byte_t vram_shadow [0:2047];
    ppu_pkg::byte_t pal_shadow [0:31];
    ppu_pkg::byte_t oam_shadow [0:255];
    ppu_pkg::byte_t wram_shadow [0:2047];

    ppu_sys_top dut0 (
        .clk(clk), .rst_n(rst_n), .cpu_clk_en(cpu_clk_en), .ppu_clk_en(ppu_clk_en),
        .cpu_cyc_par(cpu_cyc_par), .reg_sel(reg_sel), .reg_en(reg_en), .reg_rw(reg_rw),
        .reg_data_in(reg_data_in), .reg_data_out(reg_data_out), .mirroring(mirroring),
        .status_evt(status_evt), .cpu_sus(cpu_sus), .ppuctrl(ppuctrl), .ppumask(ppumask),
        .scroll_x(scroll_x), .scroll_y(scroll_y), .wram_en(wram_en), .wram_we(wram_we),
        .wram_addr(wram_addr), .wram_wdata(wram_wdata), .wram_rdata(wram_rdata)
    );

    always #5 clk = ~clk;

    // cpu tick every third cycle
    always @(posedge clk) begin
        cyc <= cyc + 1;
        #1;
        cpu_clk_en = (cyc % 3 == 0);
    end

    function automatic ppu_pkg::byte_t lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // four logical tables folded onto two physical ones
    function automatic ppu_pkg::vram_addr_t map_vram(ppu_pkg::ppu_addr_t a,
                                                     ppu_pkg::mirror_t m);
        int table_idx;
        int table_sel;
        table_idx = int'(a[11:10]);
        if (m == ppu_pkg::VER_MIRROR) begin
            table_sel = table_idx % 2;
        end else begin
            table_sel = table_idx / 2;
        end
        return 11'(table_sel * 1024 + int'(a[9:0]));
    endfunction

    function automatic ppu_pkg::pal_addr_t map_pal(ppu_pkg::ppu_addr_t a);
        int idx;
        idx = int'(a[4:0]);
        // sprite backdrop slots share the background ones
        if ((idx >= 16) && (idx % 4 == 0)) begin
            idx = idx - 16;
        end
        return 5'(idx);
    endfunction

    function automatic ppu_pkg::ppu_addr_t next_addr(ppu_pkg::ppu_addr_t a, ppu_pkg::byte_t ctrl);
        return ctrl[2] ? a + 16'd32 : a + 16'd1;
    endfunction

    function automatic ppu_pkg::byte_t status_ref(logic vbl, logic zero, logic over,
                                                  logic [4:0] low);
        return {vbl, zero, over, low};
    endfunction

    task automatic check_byte(string name, ppu_pkg::byte_t got, ppu_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got 0x%02h expected 0x%02h",
                     $time, name, got, exp);
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    task automatic idle(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // returns 1 ns into the next cycle that carries cpu_clk_en
    task automatic next_tick();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while ((cyc % 3 != 0) && (n < TICK_LIMIT));
        if (cyc % 3 != 0) begin
            abort_run("a cpu tick");
        end
    endtask

    task automatic reg_write(ppu_pkg::reg_t sel, ppu_pkg::byte_t data);
        next_tick();
        reg_sel     = sel;
        reg_en      = 1'b1;
        reg_rw      = 1'b1;
        reg_data_in = data;
        @(posedge clk);
        #1;
        reg_en  = 1'b0;
        last_wr = data[4:0];
    endtask

    task automatic reg_read(ppu_pkg::reg_t sel, output ppu_pkg::byte_t data);
        next_tick();
        reg_sel = sel;
        reg_en  = 1'b1;
        reg_rw  = 1'b0;
        @(posedge clk);
        #1;
        reg_en = 1'b0;
        data   = reg_data_out;
    endtask

    // returns 1 ns into a cycle where the dma does not hold the port
    task automatic wait_wram_free();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (cpu_sus && (n < DMA_LIMIT));
        if (cpu_sus) begin
            abort_run("the work RAM port to be free");
        end
    endtask

    task automatic wram_write(ppu_pkg::wram_addr_t addr, ppu_pkg::byte_t data);
        wait_wram_free();
        wram_en    = 1'b1;
        wram_we    = 1'b1;
        wram_addr  = addr;
        wram_wdata = data;
        @(posedge clk);
        #1;
        wram_en = 1'b0;
        wram_we = 1'b0;
        wram_shadow[addr] = data;
    endtask

    task automatic wram_read(ppu_pkg::wram_addr_t addr, output ppu_pkg::byte_t data);
        wait_wram_free();
        wram_en   = 1'b1;
        wram_we   = 1'b0;
        wram_addr = addr;
        @(posedge clk);
        #1;
        wram_en = 1'b0;
        data    = wram_rdata;
    endtask

    task automatic set_vaddr(ppu_pkg::ppu_addr_t a);
        reg_write(ppu_pkg::PPUADDR, a[15:8]);
        reg_write(ppu_pkg::PPUADDR, a[7:0]);
    endtask

    task automatic pulse_evt(ppu_pkg::status_evt_t evt);
        @(posedge clk);
        #1;
        status_evt = evt;
        @(posedge clk);
        #1;
        status_evt = '0;
    endtask

    task automatic video_pass(ppu_pkg::ppu_addr_t base, ppu_pkg::byte_t ctrl, int n);
        ppu_pkg::ppu_addr_t a;
        ppu_pkg::byte_t     d;
        reg_write(ppu_pkg::PPUCTRL, ctrl);
        set_vaddr(base);
        a = base;
        for (int i = 0; i < n; i++) begin
            d = lcg_byte();
            reg_write(ppu_pkg::PPUDATA, d);
            vram_shadow[map_vram(a, mirroring)] = d;
            a = next_addr(a, ctrl);
        end
        set_vaddr(base);
        // first read only primes the buffer
        reg_read(ppu_pkg::PPUDATA, d);
        a = base;
        for (int i = 0; i < n; i++) begin
            reg_read(ppu_pkg::PPUDATA, d);
            check_byte("reg_data_out vram", d, vram_shadow[map_vram(a, mirroring)]);
            a = next_addr(a, ctrl);
        end
    endtask

    task automatic alias_pass(ppu_pkg::ppu_addr_t a, ppu_pkg::ppu_addr_t alias_a);
        ppu_pkg::byte_t d;
        set_vaddr(a);
        d = lcg_byte();
        reg_write(ppu_pkg::PPUDATA, d);
        vram_shadow[map_vram(a, mirroring)] = d;
        set_vaddr(alias_a);
        d = lcg_byte();
        reg_write(ppu_pkg::PPUDATA, d);
        vram_shadow[map_vram(alias_a, mirroring)] = d;
        set_vaddr(a);
        reg_read(ppu_pkg::PPUDATA, d);
        reg_read(ppu_pkg::PPUDATA, d);
        check_byte("reg_data_out alias", d, vram_shadow[map_vram(a, mirroring)]);
    endtask

    task automatic palette_pass();
        ppu_pkg::ppu_addr_t a;
        ppu_pkg::byte_t     d;
        reg_write(ppu_pkg::PPUCTRL, 8'h00);
        set_vaddr(16'h3F00);
        a = 16'h3F00;
        for (int i = 0; i < 32; i++) begin
            d = lcg_byte();
            reg_write(ppu_pkg::PPUDATA, d);
            pal_shadow[map_pal(a)] = d;
            a = next_addr(a, 8'h00);
        end
        set_vaddr(16'h3F00);
        a = 16'h3F00;
        for (int i = 0; i < 32; i++) begin
            reg_read(ppu_pkg::PPUDATA, d);
            check_byte("reg_data_out palette", d, pal_shadow[map_pal(a)]);
            a = next_addr(a, 8'h00);
        end
    endtask

    task automatic oam_dump_check();
        ppu_pkg::byte_t d;
        for (int i = 0; i < 256; i++) begin
            reg_write(ppu_pkg::OAMADDR, 8'(i));
            reg_read(ppu_pkg::OAMDATA, d);
            check_byte("reg_data_out oam", d, oam_shadow[i]);
        end
    endtask

    task automatic dma_pass(ppu_pkg::byte_t page, ppu_pkg::byte_t base, logic par);
        int                  ticks;
        ppu_pkg::oam_addr_t  oa;
        ppu_pkg::wram_addr_t wa;
        ppu_pkg::byte_t      d;
        for (int i = 0; i < 256; i++) begin
            wa = {page[2:0], 8'(i)};
            wram_write(wa, lcg_byte());
        end
        reg_write(ppu_pkg::OAMADDR, base);
        cpu_cyc_par = par;
        reg_write(ppu_pkg::OAMDMA, page);
        // ticks owned by the dma including the releasing write tick
        ticks = 0;
        next_tick();
        check_level("cpu_sus", cpu_sus, 1'b1);
        while (cpu_sus && (ticks < DMA_LIMIT)) begin
            ticks++;
            next_tick();
        end
        if (cpu_sus) begin
            abort_run("cpu_sus to fall after the sprite DMA");
        end
        ticks++;
        check_count("dma ticks", ticks, 1 + int'(par) + 2 * ppu_pkg::DMA_LEN);
        cpu_cyc_par = 1'b0;
        // source page read back through the cpu port
        for (int i = 0; i < 256; i++) begin
            wa = {page[2:0], 8'(i)};
            wram_read(wa, d);
            check_byte("wram_rdata", d, wram_shadow[wa]);
        end
        for (int i = 0; i < 256; i++) begin
            oa = base + 8'(i);
            wa = {page[2:0], 8'(i)};
            oam_shadow[oa] = wram_shadow[wa];
        end
        oam_dump_check();
    endtask

    initial begin
        ppu_pkg::byte_t       d;
        ppu_pkg::status_evt_t evt;
        rst_n       = 1'b0;
        ppu_clk_en  = 1'b1;
        cpu_cyc_par = 1'b0;
        reg_sel     = ppu_pkg::PPUCTRL;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_data_in = '0;
        mirroring   = ppu_pkg::VER_MIRROR;
        status_evt  = '0;
        wram_en     = 1'b0;
        wram_we     = 1'b0;
        wram_addr   = '0;
        wram_wdata  = '0;
        lcg_state   = 43;
        errors      = 0;
        checks      = 0;
        last_wr     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_level("cpu_sus", cpu_sus, 1'b0);
        check_byte("ppuctrl", ppuctrl, 8'h00);
        check_byte("ppumask", ppumask, 8'h00);
        check_byte("scroll_x", scroll_x, 8'h00);
        check_byte("scroll_y", scroll_y, 8'h00);
        reg_read(ppu_pkg::PPUSTATUS, d);
        check_byte("status", d, 8'h00);

        reg_write(ppu_pkg::PPUCTRL, 8'hA8);
        reg_write(ppu_pkg::PPUMASK, 8'h1E);
        reg_write(ppu_pkg::PPUSCROLL, 8'h35);
        reg_write(ppu_pkg::PPUSCROLL, 8'h6C);
        check_byte("ppuctrl", ppuctrl, 8'hA8);
        check_byte("ppumask", ppumask, 8'h1E);
        check_byte("scroll_x", scroll_x, 8'h35);
        check_byte("scroll_y", scroll_y, 8'h6C);
        reg_read(ppu_pkg::PPUSTATUS, d);
        check_byte("status", d, status_ref(1'b0, 1'b0, 1'b0, last_wr));

        for (int m = 0; m < 2; m++) begin
            mirroring = (m == 0) ? ppu_pkg::VER_MIRROR : ppu_pkg::HOR_MIRROR;
            video_pass(16'h2040, 8'h00, 16);
            video_pass(16'h2805, 8'h04, 16);
            alias_pass(16'h2123, (m == 0) ? 16'h2923 : 16'h2523);
            alias_pass(16'h2210, 16'h3210);
        end
        palette_pass();

        reg_write(ppu_pkg::OAMADDR, 8'h10);
        for (int i = 0; i < 8; i++) begin
            d = lcg_byte();
            reg_write(ppu_pkg::OAMDATA, d);
            oam_shadow[16 + i] = d;
        end
        for (int i = 0; i < 8; i++) begin
            reg_write(ppu_pkg::OAMADDR, 8'(16 + i));
            reg_read(ppu_pkg::OAMDATA, d);
            check_byte("reg_data_out oam", d, oam_shadow[16 + i]);
        end
        dma_pass(8'h03, 8'h25, 1'b0);
        dma_pass(8'h05, 8'hC1, 1'b1);

        // status flags where clear beats set
        idle(4);
        evt = '0;
        evt.sp_over_set = 1'b1;
        evt.sp_zero_set = 1'b1;
        pulse_evt(evt);
        reg_read(ppu_pkg::PPUSTATUS, d);
        check_byte("status", d, status_ref(1'b0, 1'b1, 1'b1, last_wr));
        idle(4);
        evt = '0;
        evt.vblank_set  = 1'b1;
        evt.sp_over_set = 1'b1;
        evt.sp_over_clr = 1'b1;
        pulse_evt(evt);
        reg_read(ppu_pkg::PPUSTATUS, d);
        check_byte("status", d, status_ref(1'b1, 1'b1, 1'b0, last_wr));
        idle(4);
        reg_read(ppu_pkg::PPUSTATUS, d);
        check_byte("status", d, status_ref(1'b0, 1'b1, 1'b0, last_wr));
        idle(4);
        evt = '0;
        evt.vblank_set  = 1'b1;
        evt.vblank_clr  = 1'b1;
        evt.sp_zero_clr = 1'b1;
        pulse_evt(evt);
        reg_read(ppu_pkg::PPUSTATUS, d);
        check_byte("status", d, status_ref(1'b0, 1'b0, 1'b0, last_wr));

        finish_run();
    end

endmodule

// File: all.f
verilog/ppu_pkg.sv
verilog/ppu_reg_file.sv
verilog/oam_dma.sv
verilog/ppu_mem.sv
verilog/cpu_wram.sv
verilog/ppu_sys_top.sv
bench/tb_ppu_sys.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f all.f --top-module tb_ppu_sys -o tb_ppu_sys

./obj_dir/tb_ppu_sys | tee sim.log

# pass only when the testbench reported success
grep -q "^TB PASSED$" sim.log
echo "simulation passed"
